//--- mpi_defs.svh
/* Message passing interface constants
   Bus and flit widths, buffer depth and register address layout */

`ifndef MPI_DEFS_SVH
`define MPI_DEFS_SVH

// Bus word and flit payload width
`define MPI_DATA_W 32

// Flit type field, no multicast bits
`define MPI_KIND_W 2

// Packet length field, up to 31 flits
`define MPI_SIZE_W 5

// Flits per packet buffer
// A packet longer than this can never be released
`define MPI_FIFO_DEPTH 16

// Byte address of the bus
`define MPI_ADDR_W 6

// Register select is the word address
`define MPI_REG_LSB 2
`define MPI_REG_W (`MPI_ADDR_W - `MPI_REG_LSB)

`endif

//--- mpi_pkg.sv
/* Message passing interface types
   Flit and bus request structs, register select and FSM states */

`include "mpi_defs.svh"

package mpi_pkg;

  // Flit type carried in the upper bits of every flit
  typedef enum logic [`MPI_KIND_W-1:0] {
    KIND_PAYLOAD = 2'b00,
    KIND_HEADER  = 2'b01,
    KIND_LAST    = 2'b10,
    KIND_SINGLE  = 2'b11
  } flit_kind_e;

  // Type on top, payload below, 34 bits
  typedef struct packed {
    flit_kind_e              kind;
    logic [`MPI_DATA_W-1:0]  data;
  } noc_flit_t;

  // One bus request as seen by the decoder
  typedef struct packed {
    logic                    en;
    logic                    we;
    logic [`MPI_ADDR_W-1:0]  addr;
    logic [`MPI_DATA_W-1:0]  wdata;
  } bus_req_t;

  // Word address decode, other values select nothing
  typedef enum logic [`MPI_REG_W-1:0] {
    REG_FIFO   = 'd0,
    REG_STATUS = 'd1
  } reg_sel_e;

  typedef enum logic [1:0] {
    EG_IDLE,
    EG_FIRST,
    EG_PAYLOAD
  } egress_state_e;

  typedef enum logic {
    IN_IDLE,
    IN_FLIT
  } ingress_state_e;

endpackage

//--- packet_buffer.sv
/* Store-and-forward packet buffer
   Releases flits only once a whole packet is stored, reports head length */

`include "mpi_defs.svh"

module packet_buffer #(
  parameter int DEPTH = `MPI_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst,
  input  mpi_pkg::noc_flit_t      in_flit,
  input  logic                    in_valid,
  output logic                    in_ready,
  output mpi_pkg::noc_flit_t      out_flit,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic [`MPI_SIZE_W-1:0]  out_size
);
  import mpi_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  noc_flit_t              flit_mem [DEPTH];
  // One entry per complete packet, never more packets than flits
  logic [`MPI_SIZE_W-1:0] size_mem [DEPTH];

  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [PTR_W-1:0]       sz_wr_ptr;
  logic [PTR_W-1:0]       sz_rd_ptr;
  logic [CNT_W-1:0]       flit_cnt;
  logic [CNT_W-1:0]       flit_cnt_nxt;
  logic [CNT_W-1:0]       pkt_cnt;
  // Flits of the packet currently being written
  logic [`MPI_SIZE_W-1:0] run_len;

  logic                   push;
  logic                   pop;
  logic                   push_end;
  logic                   pop_end;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // LAST and SINGLE close a packet
  function automatic logic is_end(input flit_kind_e kind);
    return (kind == KIND_LAST) || (kind == KIND_SINGLE);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  assign push     = in_valid && in_ready;
  assign pop      = out_valid && out_ready;
  assign push_end = push && is_end(in_flit.kind);
  assign pop_end  = pop && is_end(out_flit.kind);

  assign flit_cnt_nxt = flit_cnt + CNT_W'(push) - CNT_W'(pop);

  // Head is visible only when a whole packet sits in the buffer
  assign out_valid = (pkt_cnt != '0);
  assign out_flit  = flit_mem[rd_ptr];
  assign out_size  = size_mem[sz_rd_ptr];

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      sz_wr_ptr <= '0;
      sz_rd_ptr <= '0;
      flit_cnt  <= '0;
      pkt_cnt   <= '0;
      run_len   <= '0;
      in_ready  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr  <= ptr_inc(wr_ptr);
        run_len <= push_end ? '0 : run_len + 1'b1;
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (push_end) begin
        sz_wr_ptr <= ptr_inc(sz_wr_ptr);
      end
      if (pop_end) begin
        sz_rd_ptr <= ptr_inc(sz_rd_ptr);
      end
      flit_cnt <= flit_cnt_nxt;
      pkt_cnt  <= pkt_cnt + CNT_W'(push_end) - CNT_W'(pop_end);
      // Registered full flag, also keeps ready low through reset
      in_ready <= (flit_cnt_nxt != CNT_W'(DEPTH));
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      flit_mem[wr_ptr] <= in_flit;
    end
    if (push_end) begin
      // Length includes the closing flit
      size_mem[sz_wr_ptr] <= run_len + 1'b1;
    end
  end

endmodule

//--- egress_path.sv
/* Egress FSM
   Takes a length and then that many bus words, emits typed flits */

`include "mpi_defs.svh"

module egress_path (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fifo_wr,
  input  logic [`MPI_DATA_W-1:0]  wdata,
  output logic                    eg_ack,
  output mpi_pkg::noc_flit_t      eg_flit,
  output logic                    eg_valid,
  input  logic                    eg_ready
);
  import mpi_pkg::*;

  egress_state_e          state;
  egress_state_e          state_nxt;
  // Flits still to send in this packet
  logic [`MPI_SIZE_W-1:0] remain;
  logic [`MPI_SIZE_W-1:0] remain_nxt;
  logic                   one_left;

  assign one_left = (remain == `MPI_SIZE_W'(1));

  always_comb begin
    state_nxt    = state;
    remain_nxt   = remain;
    eg_ack       = 1'b0;
    eg_valid     = 1'b0;
    // Bus word goes straight into the flit payload
    eg_flit.data = wdata;
    eg_flit.kind = KIND_PAYLOAD;

    case (state)
      EG_IDLE: begin
        // First write of a packet is its length
        if (fifo_wr) begin
          eg_ack     = 1'b1;
          remain_nxt = wdata[`MPI_SIZE_W-1:0];
          // Zero length sends nothing
          if (wdata[`MPI_SIZE_W-1:0] != '0) begin
            state_nxt = EG_FIRST;
          end
        end
      end
      EG_FIRST, EG_PAYLOAD: begin
        if (fifo_wr) begin
          eg_valid = 1'b1;
          if (state == EG_FIRST) begin
            eg_flit.kind = one_left ? KIND_SINGLE : KIND_HEADER;
          end else begin
            eg_flit.kind = one_left ? KIND_LAST : KIND_PAYLOAD;
          end
          // Ack only once the buffer takes the flit
          if (eg_ready) begin
            eg_ack     = 1'b1;
            remain_nxt = remain - 1'b1;
            state_nxt  = one_left ? EG_IDLE : EG_PAYLOAD;
          end
        end
      end
      default: begin
        state_nxt = EG_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= EG_IDLE;
      remain <= '0;
    end else begin
      state  <= state_nxt;
      remain <= remain_nxt;
    end
  end

endmodule

//--- ingress_path.sv
/* Ingress FSM
   Hands the head packet length and then its words to bus reads */

`include "mpi_defs.svh"

module ingress_path (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fifo_rd,
  input  mpi_pkg::noc_flit_t      head_flit,
  input  logic                    head_valid,
  input  logic [`MPI_SIZE_W-1:0]  head_size,
  output logic                    pop,
  output logic                    in_ack,
  output logic [`MPI_DATA_W-1:0]  in_data
);
  import mpi_pkg::*;

  ingress_state_e state;
  ingress_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    pop       = 1'b0;
    in_ack    = 1'b0;
    in_data   = '0;

    case (state)
      IN_IDLE: begin
        // Length read, answers 0 when nothing is waiting
        if (fifo_rd) begin
          in_ack = 1'b1;
          if (head_valid) begin
            in_data = `MPI_DATA_W'(head_size);
            if (head_size != '0) begin
              state_nxt = IN_FLIT;
            end
          end
        end
      end
      IN_FLIT: begin
        // Head packet is complete, so a flit is always there
        if (fifo_rd && head_valid) begin
          in_ack  = 1'b1;
          pop     = 1'b1;
          in_data = head_flit.data;
          if (head_flit.kind == KIND_LAST || head_flit.kind == KIND_SINGLE) begin
            state_nxt = IN_IDLE;
          end
        end
      end
      default: begin
        state_nxt = IN_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IN_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

//--- mpi_bus_decode.sv
/* Bus register decoder
   Steers word 0 to the egress or ingress path, answers status itself */

`include "mpi_defs.svh"

module mpi_bus_decode (
  input  mpi_pkg::bus_req_t       req,
  output logic                    fifo_wr,
  output logic                    fifo_rd,
  input  logic                    eg_ack,
  input  logic                    in_ack,
  input  logic [`MPI_DATA_W-1:0]  in_data,
  input  logic                    out_pending,
  input  logic                    irq,
  output logic                    bus_ack,
  output logic [`MPI_DATA_W-1:0]  bus_rdata
);
  import mpi_pkg::*;

  reg_sel_e sel;

  assign sel = reg_sel_e'(req.addr[`MPI_ADDR_W-1:`MPI_REG_LSB]);

  always_comb begin
    fifo_wr   = 1'b0;
    fifo_rd   = 1'b0;
    bus_ack   = 1'b0;
    bus_rdata = '0;

    if (req.en) begin
      case (sel)
        REG_FIFO: begin
          if (req.we) begin
            fifo_wr = 1'b1;
            bus_ack = eg_ack;
          end else begin
            fifo_rd   = 1'b1;
            bus_ack   = in_ack;
            bus_rdata = in_data;
          end
        end
        REG_STATUS: begin
          // Writes here have no effect
          bus_ack = 1'b1;
          if (!req.we) begin
            bus_rdata = {{(`MPI_DATA_W-2){1'b0}}, out_pending, irq};
          end
        end
        default: begin
          // Unmapped, ack with zero data
          bus_ack = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- mpi.sv
/* Message passing interface top
   Bus register access on one side, NoC flit ports on the other */

`include "mpi_defs.svh"

module mpi (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    bus_en,
  input  logic                    bus_we,
  input  logic [`MPI_ADDR_W-1:0]  bus_addr,
  input  logic [`MPI_DATA_W-1:0]  bus_wdata,
  output logic [`MPI_DATA_W-1:0]  bus_rdata,
  output logic                    bus_ack,
  output mpi_pkg::noc_flit_t      noc_out_flit,
  output logic                    noc_out_valid,
  input  logic                    noc_out_ready,
  input  mpi_pkg::noc_flit_t      noc_in_flit,
  input  logic                    noc_in_valid,
  output logic                    noc_in_ready,
  output logic                    irq
);
  import mpi_pkg::*;

  bus_req_t               req;
  logic                   fifo_wr;
  logic                   fifo_rd;
  // Egress path to outgoing buffer
  logic                   eg_ack;
  noc_flit_t              eg_flit;
  logic                   eg_valid;
  logic                   eg_ready;
  // Incoming buffer to ingress path
  logic                   in_ack;
  logic [`MPI_DATA_W-1:0] in_data;
  noc_flit_t              head_flit;
  logic                   head_valid;
  logic [`MPI_SIZE_W-1:0] head_size;
  logic                   pop;

  assign req = '{en: bus_en, we: bus_we, addr: bus_addr, wdata: bus_wdata};

  // A complete packet waiting raises the interrupt
  assign irq = head_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////////////

  mpi_bus_decode u_decode (
    .req         (req),
    .fifo_wr     (fifo_wr),
    .fifo_rd     (fifo_rd),
    .eg_ack      (eg_ack),
    .in_ack      (in_ack),
    .in_data     (in_data),
    .out_pending (noc_out_valid),
    .irq         (irq),
    .bus_ack     (bus_ack),
    .bus_rdata   (bus_rdata)
  );

  egress_path u_egress (
    .clk      (clk),
    .rst      (rst),
    .fifo_wr  (fifo_wr),
    .wdata    (req.wdata),
    .eg_ack   (eg_ack),
    .eg_flit  (eg_flit),
    .eg_valid (eg_valid),
    .eg_ready (eg_ready)
  );

  ingress_path u_ingress (
    .clk        (clk),
    .rst        (rst),
    .fifo_rd    (fifo_rd),
    .head_flit  (head_flit),
    .head_valid (head_valid),
    .head_size  (head_size),
    .pop        (pop),
    .in_ack     (in_ack),
    .in_data    (in_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // NoC side buffers
  ////////////////////////////////////////////////////////////////////////////

  // Length of outgoing packets is not needed
  packet_buffer #(
    .DEPTH (`MPI_FIFO_DEPTH)
  ) u_buf_out (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (eg_flit),
    .in_valid  (eg_valid),
    .in_ready  (eg_ready),
    .out_flit  (noc_out_flit),
    .out_valid (noc_out_valid),
    .out_ready (noc_out_ready),
    .out_size  ()
  );

  packet_buffer #(
    .DEPTH (`MPI_FIFO_DEPTH)
  ) u_buf_in (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (head_flit),
    .out_valid (head_valid),
    .out_ready (pop),
    .out_size  (head_size)
  );

endmodule

//--- tb_mpi.sv
/* Testbench for the message passing interface
   Table of packets sent out over the bus, then fed back in from the NoC */

`include "mpi_defs.svh"

module tb_mpi;
  timeunit 1ns;
  timeprecision 1ps;
  import mpi_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYC = 10;
  localparam int NUM_PKT = 8;
  localparam int MAX_LEN = 6;
  // Outputs settle well before the next rising edge
  localparam int SETTLE = 5;
  localparam int WATCHDOG_NS = NUM_PKT * 64 * 2 * HALF_PERIOD + RST_CYC * 2 * HALF_PERIOD;
  localparam logic [`MPI_ADDR_W-1:0] ADDR_FIFO = `MPI_ADDR_W'(0);
  localparam logic [`MPI_ADDR_W-1:0] ADDR_STATUS = `MPI_ADDR_W'(4);
  localparam logic [`MPI_ADDR_W-1:0] ADDR_UNMAPPED = `MPI_ADDR_W'(12);

  logic                   clk;
  logic                   rst;
  logic                   bus_en;
  logic                   bus_we;
  logic [`MPI_ADDR_W-1:0] bus_addr;
  logic [`MPI_DATA_W-1:0] bus_wdata;
  logic [`MPI_DATA_W-1:0] bus_rdata;
  logic                   bus_ack;
  noc_flit_t              noc_out_flit;
  logic                   noc_out_valid;
  logic                   noc_out_ready;
  noc_flit_t              noc_in_flit;
  logic                   noc_in_valid;
  logic                   noc_in_ready;
  logic                   irq;

  // Packet table with length and random ready flag for noc_out
  int          pkt_len [NUM_PKT] = '{1, 2, 3, 4, 5, 6, 5, 6};
  bit          pkt_bp  [NUM_PKT] = '{0, 0, 1, 0, 1, 1, 0, 1};
  logic [31:0] pkt_word [NUM_PKT][MAX_LEN];
  logic [31:0] rng_state;

  mpi u_mpi (
    .clk           (clk),
    .rst           (rst),
    .bus_en        (bus_en),
    .bus_we        (bus_we),
    .bus_addr      (bus_addr),
    .bus_wdata     (bus_wdata),
    .bus_rdata     (bus_rdata),
    .bus_ack       (bus_ack),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .irq           (irq)
  );

  always #HALF_PERIOD clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Flit type by position in a packet of len flits
  function automatic flit_kind_e expected_kind(input int idx, input int len);
    if (len == 1) begin
      return KIND_SINGLE;
    end
    if (idx == 0) begin
      return KIND_HEADER;
    end
    if (idx == len - 1) begin
      return KIND_LAST;
    end
    return KIND_PAYLOAD;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("FAIL %s expected 0x%0h got 0x%0h", name, exp, got);
      $display("Result: FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Called at a falling edge and holds the request until ack is seen
  task automatic bus_access(input logic we, input logic [`MPI_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic acked;
    acked     = 1'b0;
    rdata     = '0;
    bus_en    = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = wdata;
    while (!acked) begin
      #SETTLE;
      acked = bus_ack;
      rdata = bus_rdata;
      @(negedge clk);
    end
    bus_en = 1'b0;
    bus_we = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [`MPI_ADDR_W-1:0] addr,
                             input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(1'b0, addr, '0, rd);
    check(name, exp, rd);
  endtask

  // Length, then the words, then collect the flits from noc_out
  task automatic send_egress(input int p);
    logic [31:0] rd;
    noc_flit_t   got;
    int          n;
    bus_access(1'b1, ADDR_FIFO, 32'(pkt_len[p]), rd);
    for (int i = 0; i < pkt_len[p]; i++) begin
      // Store and forward holds everything back until the last word
      check("noc_out_valid", 32'd0, 32'(noc_out_valid));
      bus_access(1'b1, ADDR_FIFO, pkt_word[p][i], rd);
    end
    check("noc_out_valid", 32'd1, 32'(noc_out_valid));
    read_expect("status", ADDR_STATUS, 32'h2);
    n = 0;
    while (n < pkt_len[p]) begin
      if (pkt_bp[p]) begin
        rng_state     = xorshift32(rng_state);
        noc_out_ready = rng_state[0];
      end else begin
        noc_out_ready = 1'b1;
      end
      #SETTLE;
      if (noc_out_valid && noc_out_ready) begin
        got = noc_out_flit;
        check("noc_out_flit.kind", 32'(expected_kind(n, pkt_len[p])), 32'(got.kind));
        check("noc_out_flit.data", pkt_word[p][n], got.data);
        n++;
      end
      @(negedge clk);
    end
    noc_out_ready = 1'b0;
    check("noc_out_valid", 32'd0, 32'(noc_out_valid));
  endtask

  // Typed flits on noc_in are each held until the buffer takes them
  task automatic send_ingress(input int p);
    logic taken;
    for (int i = 0; i < pkt_len[p]; i++) begin
      noc_in_flit.kind = expected_kind(i, pkt_len[p]);
      noc_in_flit.data = pkt_word[p][i];
      noc_in_valid     = 1'b1;
      taken            = 1'b0;
      while (!taken) begin
        #SETTLE;
        taken = noc_in_ready;
        @(negedge clk);
      end
    end
    noc_in_valid = 1'b0;
  endtask

  task automatic read_packet(input int p);
    read_expect("length", ADDR_FIFO, 32'(pkt_len[p]));
    for (int i = 0; i < pkt_len[p]; i++) begin
      // Packet stays flagged until its last word is popped
      check("irq", 32'd1, 32'(irq));
      read_expect("word", ADDR_FIFO, pkt_word[p][i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    clk           = 1'b0;
    rst           = 1'b1;
    bus_en        = 1'b0;
    bus_we        = 1'b0;
    bus_addr      = '0;
    bus_wdata     = '0;
    noc_out_ready = 1'b0;
    noc_in_flit   = '0;
    noc_in_valid  = 1'b0;
    rng_state     = 32'd46;
    for (int p = 0; p < NUM_PKT; p++) begin
      for (int i = 0; i < MAX_LEN; i++) begin
        rng_state      = xorshift32(rng_state);
        pkt_word[p][i] = rng_state;
      end
    end

    repeat (RST_CYC) @(negedge clk);
    check("bus_ack", 32'd0, 32'(bus_ack));
    check("noc_out_valid", 32'd0, 32'(noc_out_valid));
    check("noc_in_ready", 32'd0, 32'(noc_in_ready));
    check("irq", 32'd0, 32'(irq));
    rst = 1'b0;

    // Idle state after reset
    read_expect("status", ADDR_STATUS, 32'h0);
    read_expect("length", ADDR_FIFO, 32'h0);
    read_expect("unmapped", ADDR_UNMAPPED, 32'h0);
    bus_access(1'b1, ADDR_STATUS, 32'hffff_ffff, rd);
    read_expect("status", ADDR_STATUS, 32'h0);
    check("noc_in_ready", 32'd1, 32'(noc_in_ready));

    // Each packet out through the bus and back in from the NoC
    for (int p = 0; p < NUM_PKT; p++) begin
      send_egress(p);
      send_ingress(p);
      while (!irq) @(negedge clk);
      read_expect("status", ADDR_STATUS, 32'h1);
      read_packet(p);
      check("irq", 32'd0, 32'(irq));
    end

    // Two packets waiting are read in arrival order
    send_ingress(NUM_PKT - 2);
    send_ingress(NUM_PKT - 1);
    check("irq", 32'd1, 32'(irq));
    read_packet(NUM_PKT - 2);
    check("irq", 32'd1, 32'(irq));
    read_packet(NUM_PKT - 1);
    check("irq", 32'd0, 32'(irq));

    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #WATCHDOG_NS;
    $display("Run timed out waiting for the DUT");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- mpi.f
+incdir+.
mpi_pkg.sv
packet_buffer.sv
egress_path.sv
ingress_path.sv
mpi_bus_decode.sv
mpi.sv
tb_mpi.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_mpi -f mpi.f -o tb_mpi
./obj_dir/tb_mpi
